//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	typedef logic [31:0] word_t;   // instruction or data word
	typedef logic [31:0] addr_t;   // byte address

	// cache geometry
	localparam int unsigned LINE_WORDS  = 8;                       // one 8-beat burst per line
	localparam int unsigned LINE_BYTES  = LINE_WORDS * 4;          // 32 bytes
	localparam int unsigned INDEX_BITS  = 4;                       // 16 lines
	localparam int unsigned NUM_LINES   = 1 << INDEX_BITS;
	localparam int unsigned WOFF_BITS   = $clog2(LINE_WORDS);      // word within line
	localparam int unsigned OFFSET_BITS = $clog2(LINE_BYTES);      // byte within line
	localparam int unsigned TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;   // line select
	typedef logic [TAG_BITS-1:0]   tag_t;     // upper address bits kept per line
	typedef logic [WOFF_BITS-1:0]  woff_t;    // word select inside a line

	localparam addr_t RESET_PC    = 32'h3000_0000;   // boot rom, not cached
	localparam addr_t SDRAM_BASE  = 32'ha000_0000;   // cacheable window, inclusive
	localparam addr_t SDRAM_LIMIT = 32'ha200_0000;   // exclusive

	// axi burst codes
	localparam logic [1:0] BURST_FIXED = 2'b00;
	localparam logic [1:0] BURST_INCR  = 2'b01;

	localparam logic [6:0] OP_JAL = 7'b110_1111;

	typedef enum logic [2:0] {
		IDLE,     // pick lookup or direct request for pc
		LOOKUP,   // cache answers this cycle
		REQ,      // ar channel waiting for arready
		RESP,     // single uncached beat
		REFILL,   // line burst going into the cache
		HOLD      // instruction offered to decode
	} fetch_state_t;

endpackage

`default_nettype wire

//--- hdl/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
	input  logic             clock,
	input  logic             rst_n,

	input  logic             lookup_valid,
	input  fetch_pkg::addr_t lookup_addr,
	output logic             hit,
	output fetch_pkg::word_t hit_data,

	input  logic             refill_valid,
	input  logic             refill_last,
	input  fetch_pkg::addr_t refill_addr,
	input  fetch_pkg::word_t refill_data
);
	import fetch_pkg::*;

	word_t                data_mem [NUM_LINES*LINE_WORDS];   // line-major word store
	tag_t                 tag_mem  [NUM_LINES];
	logic [NUM_LINES-1:0] line_valid;

	index_t l_index;
	woff_t  l_woff;
	tag_t   l_tag;
	index_t r_index;
	woff_t  r_woff;
	tag_t   r_tag;

	// split both addresses into tag / index / word fields
	assign l_index = lookup_addr[OFFSET_BITS +: INDEX_BITS];
	assign l_woff  = lookup_addr[2 +: WOFF_BITS];
	assign l_tag   = lookup_addr[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
	assign r_index = refill_addr[OFFSET_BITS +: INDEX_BITS];
	assign r_woff  = refill_addr[2 +: WOFF_BITS];
	assign r_tag   = refill_addr[OFFSET_BITS+INDEX_BITS +: TAG_BITS];

	// registered lookup, hit only in the cycle after a request
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			hit <= 1'b0;
		end else if (lookup_valid) begin
			hit <= line_valid[l_index] && (tag_mem[l_index] == l_tag);
		end else begin
			hit <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_valid) begin
			hit_data <= data_mem[{l_index, l_woff}];   // read even on a miss, fetch ignores it
		end
	end

	// refill writes one word per beat
	always_ff @(posedge clock) begin
		if (refill_valid) begin
			data_mem[{r_index, r_woff}] <= refill_data;
		end
		if (refill_valid && refill_last) begin
			tag_mem[r_index] <= r_tag;   // tag lands with the last word
		end
	end

	// line goes invalid while being overwritten, valid again on the last beat
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			line_valid <= '0;
		end else if (refill_valid) begin
			line_valid[r_index] <= refill_last;
		end
	end

	// fetch never looks up while a line is only half written
	assert property (@(posedge clock) disable iff (!rst_n)
		!(refill_valid && lookup_valid))
	else $error("icache lookup during refill");

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  logic             clock,
	input  logic             rst_n,

	output fetch_pkg::addr_t araddr,
	output logic             arvalid,
	input  logic             arready,
	output logic [1:0]       arburst,
	output logic [3:0]       arlen,
	input  fetch_pkg::word_t rdata,
	input  logic [1:0]       rresp,
	input  logic             rlast,
	input  logic             rvalid,
	output logic             rready,

	output logic             lookup_valid,
	output fetch_pkg::addr_t lookup_addr,
	input  logic             hit,
	input  fetch_pkg::word_t hit_data,

	output logic             refill_valid,
	output logic             refill_last,
	output fetch_pkg::addr_t refill_addr,
	output fetch_pkg::word_t refill_data,

	output logic             inst_valid,
	output fetch_pkg::word_t inst,
	output fetch_pkg::addr_t inst_pc,
	input  logic             inst_ready,

	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_addr
);
	import fetch_pkg::*;

	fetch_state_t state;
	addr_t        pc;
	addr_t        line_base;
	logic         pc_in_sdram;
	logic         line_fill;   // current request is a cache line burst
	logic         squash;      // in-flight bus result is stale
	logic         beat;
	logic         want_beat;

	assign pc_in_sdram = (pc >= SDRAM_BASE) && (pc < SDRAM_LIMIT);
	assign line_base   = pc & ~addr_t'(LINE_BYTES - 1);
	assign beat        = rvalid && rready;
	assign want_beat   = refill_addr[2 +: WOFF_BITS] == pc[2 +: WOFF_BITS];   // beat holds pc's word

	assign rready       = 1'b1;   // always sink read data
	assign arvalid      = (state == REQ);
	assign arburst      = line_fill ? BURST_INCR : BURST_FIXED;
	assign arlen        = line_fill ? 4'(LINE_WORDS - 1) : 4'd0;
	assign lookup_valid = (state == IDLE) && pc_in_sdram;
	assign lookup_addr  = pc;
	assign refill_valid = (state == REFILL) && beat;
	assign refill_last  = rlast;
	assign refill_data  = rdata;
	assign inst_valid   = (state == HOLD);
	assign inst_pc      = pc;   // pc only moves once the instruction leaves

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state     <= IDLE;
			pc        <= RESET_PC;
			line_fill <= 1'b0;
			squash    <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (redirect) begin
						pc <= redirect_addr;
					end else if (pc_in_sdram) begin
						state <= LOOKUP;
					end else begin
						state     <= REQ;
						line_fill <= 1'b0;   // uncached single beat
					end
				end
				LOOKUP: begin
					if (redirect) begin
						pc    <= redirect_addr;
						state <= IDLE;
					end else if (hit) begin
						state <= HOLD;
					end else begin
						state     <= REQ;
						line_fill <= 1'b1;   // miss, fetch the whole line
					end
				end
				REQ: begin
					if (redirect) begin
						pc     <= redirect_addr;
						squash <= 1'b1;   // request can not be withdrawn
					end
					if (arready) begin
						state <= line_fill ? REFILL : RESP;
					end
				end
				RESP, REFILL: begin
					if (redirect) begin
						pc     <= redirect_addr;
						squash <= 1'b1;
					end
					if (beat && rlast) begin
						// a stale burst still fills the cache but is not delivered
						state  <= (squash || redirect) ? IDLE : HOLD;
						squash <= 1'b0;
					end
				end
				HOLD: begin
					if (redirect) begin
						pc    <= redirect_addr;   // jal taken on accept
						state <= IDLE;
					end else if (inst_ready) begin
						pc    <= pc + addr_t'(4);
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// request address, refill pointer and captured instruction
	always_ff @(posedge clock) begin
		if (state == IDLE || state == LOOKUP) begin
			araddr <= pc_in_sdram ? line_base : pc;
		end
		if (state == REQ && arready) begin
			refill_addr <= araddr;   // burst starts at the line base
		end else if (refill_valid) begin
			refill_addr <= refill_addr + addr_t'(4);
		end
		if (state == LOOKUP && hit) begin
			inst <= hit_data;
		end else if (refill_valid && want_beat) begin
			inst <= rdata;
		end else if (state == RESP && beat) begin
			inst <= rdata;
		end
	end

	assert property (@(posedge clock) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
	else $error("ar request dropped or changed before arready");

	// decode must not redirect without taking the instruction
	assert property (@(posedge clock) disable iff (!rst_n)
		inst_valid && !inst_ready |=> inst_valid && $stable(inst) && $stable(inst_pc))
	else $error("inst_valid dropped before inst_ready");

	assert property (@(posedge clock) disable iff (!rst_n)
		rvalid |-> rresp == 2'b00)
	else $error("read beat without OKAY response");

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic             clock,
	input  logic             rst_n,

	input  logic             inst_valid,
	input  fetch_pkg::word_t inst,
	input  fetch_pkg::addr_t inst_pc,
	output logic             inst_ready,

	output logic             redirect,
	output fetch_pkg::addr_t redirect_addr,

	output logic             out_valid,
	output fetch_pkg::addr_t out_pc,
	output fetch_pkg::word_t out_inst,
	input  logic             out_ready
);
	import fetch_pkg::*;

	logic  accept;
	logic  is_jal;
	addr_t jal_imm;

	assign inst_ready = !out_valid || out_ready;   // empty or draining this cycle
	assign accept     = inst_valid && inst_ready;

	assign is_jal = (inst[6:0] == OP_JAL);

	// j-type immediate, imm[20|10:1|11|19:12] scrambled into inst[31:12]
	assign jal_imm = {
		{11{inst[31]}},
		inst[31],
		inst[19:12],
		inst[20],
		inst[30:21],
		1'b0
	};

	// taken in the same cycle fetch hands the jal over
	assign redirect      = accept && is_jal;
	assign redirect_addr = inst_pc + jal_imm;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (inst_ready) begin
			out_valid <= inst_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			out_pc   <= inst_pc;
			out_inst <= inst;
		end
	end

	// a redirect comes from an accepted jal, which shows up at the output next
	assert property (@(posedge clock) disable iff (!rst_n)
		redirect |-> (inst_valid && inst_ready) ##1 (out_valid && out_inst[6:0] == OP_JAL))
	else $error("redirect without an accepted jal");

endmodule

`default_nettype wire

//--- hdl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
	input  logic             clock,
	input  logic             rst_n,

	output fetch_pkg::addr_t araddr,
	output logic             arvalid,
	input  logic             arready,
	output logic [1:0]       arburst,
	output logic [3:0]       arlen,
	input  fetch_pkg::word_t rdata,
	input  logic [1:0]       rresp,
	input  logic             rlast,
	input  logic             rvalid,
	output logic             rready,

	output logic             out_valid,
	output fetch_pkg::addr_t out_pc,
	output fetch_pkg::word_t out_inst,
	input  logic             out_ready
);
	import fetch_pkg::*;

	// fetch <-> cache
	logic  lookup_valid;
	addr_t lookup_addr;
	logic  hit;
	word_t hit_data;
	logic  refill_valid;
	logic  refill_last;
	addr_t refill_addr;
	word_t refill_data;

	// fetch <-> decode
	logic  inst_valid;
	word_t inst;
	addr_t inst_pc;
	logic  inst_ready;
	logic  redirect;
	addr_t redirect_addr;

	fetch_unit fetch_unit_inst (
		.clock         (clock),
		.rst_n         (rst_n),
		.araddr        (araddr),
		.arvalid       (arvalid),
		.arready       (arready),
		.arburst       (arburst),
		.arlen         (arlen),
		.rdata         (rdata),
		.rresp         (rresp),
		.rlast         (rlast),
		.rvalid        (rvalid),
		.rready        (rready),
		.lookup_valid  (lookup_valid),
		.lookup_addr   (lookup_addr),
		.hit           (hit),
		.hit_data      (hit_data),
		.refill_valid  (refill_valid),
		.refill_last   (refill_last),
		.refill_addr   (refill_addr),
		.refill_data   (refill_data),
		.inst_valid    (inst_valid),
		.inst          (inst),
		.inst_pc       (inst_pc),
		.inst_ready    (inst_ready),
		.redirect      (redirect),
		.redirect_addr (redirect_addr)
	);

	icache icache_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.lookup_valid (lookup_valid),
		.lookup_addr  (lookup_addr),
		.hit          (hit),
		.hit_data     (hit_data),
		.refill_valid (refill_valid),
		.refill_last  (refill_last),
		.refill_addr  (refill_addr),
		.refill_data  (refill_data)
	);

	decode_stage decode_stage_inst (
		.clock         (clock),
		.rst_n         (rst_n),
		.inst_valid    (inst_valid),
		.inst          (inst),
		.inst_pc       (inst_pc),
		.inst_ready    (inst_ready),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.out_valid     (out_valid),
		.out_pc        (out_pc),
		.out_inst      (out_inst),
		.out_ready     (out_ready)
	);

endmodule

`default_nettype wire

//--- verification/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
	import fetch_pkg::*;

	localparam int unsigned SEED       = 87114;
	localparam int unsigned RUN_LIMIT  = 100000;         // cycles for the whole program
	localparam int unsigned IDLE_LIMIT = 400;            // cycles allowed between two outputs
	localparam int unsigned LOOP_OUTS  = 24;             // four passes round the cached loop
	localparam addr_t       LINE0_BASE = 32'ha000_0200;  // first sdram line entered mid-line
	localparam addr_t       LOOP_BASE  = 32'ha000_0300;  // line holding the jal loop

	logic       clock;
	logic       rst_n;
	addr_t      araddr;
	logic       arvalid;
	logic       arready;
	logic [1:0] arburst;
	logic [3:0] arlen;
	word_t      rdata;
	logic [1:0] rresp;
	logic       rlast;
	logic       rvalid;
	logic       rready;
	logic       out_valid;
	addr_t      out_pc;
	word_t      out_inst;
	logic       out_ready;

	int unsigned mismatch_errors;
	int unsigned protocol_errors;
	int unsigned timeout_errors;
	int unsigned checked;       // out handshakes compared so far
	int unsigned loop_outs;
	int unsigned ar_count;      // ar handshakes seen by the monitor
	int unsigned ar_at_loop;
	addr_t       exp_pc;
	addr_t       ar_pc;         // next uncached pc the bus should be asked for
	addr_t       line_addrs[$];
	logic        ar_hs;         // handshakes at the coming rising edge
	logic        r_hs;
	logic        held_valid;    // out stalled at the last edge
	addr_t       held_pc;
	word_t       held_inst;

	fetch_top fetch_top_inst (
		.clock     (clock),
		.rst_n     (rst_n),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.arburst   (arburst),
		.arlen     (arlen),
		.rdata     (rdata),
		.rresp     (rresp),
		.rlast     (rlast),
		.rvalid    (rvalid),
		.rready    (rready),
		.out_valid (out_valid),
		.out_pc    (out_pc),
		.out_inst  (out_inst),
		.out_ready (out_ready)
	);

	always #10 clock = ~clock;   // 20 ns period

	// jal target at address a or zero where a holds an addi
	function automatic addr_t jal_dest(input addr_t a);
		if (a == RESET_PC + 32'h10)
			return 32'h3008_0000;   // into the hop chain
		if (a >= 32'h3008_0000 && a < 32'h9ff8_0000 && a[18:0] == '0)
			return a + 32'h8_0000;   // 512k hops stay inside the 1m jal reach
		if (a == 32'h9ff8_0000)
			return LINE0_BASE + 32'h4;   // lands on word 1 of a line
		if (a == 32'ha000_021c)
			return LOOP_BASE;
		if (a == LOOP_BASE + 32'h04)
			return LOOP_BASE + 32'h18;   // forward inside the line
		if (a == LOOP_BASE + 32'h1c)
			return LOOP_BASE + 32'h08;   // backward
		if (a == LOOP_BASE + 32'h0c)
			return LOOP_BASE;            // closes the loop
		return '0;
	endfunction

	function automatic word_t mem_word(input addr_t a);
		addr_t dest;
		addr_t off;
		dest = jal_dest(a);
		off  = dest - a;
		if (dest != '0)
			return {off[20], off[10:1], off[11], off[19:12], 5'd1, OP_JAL};   // jal x1
		return {a[13:2], 5'd5, 3'b000, 5'd5, 7'b001_0011};   // addi x5, x5, imm
	endfunction

	// expected successor of pc
	function automatic addr_t next_pc(input addr_t pc);
		word_t w;
		w = mem_word(pc);
		if (w[6:0] == OP_JAL)
			return jal_dest(pc);
		return pc + 32'd4;
	endfunction

	function automatic logic in_sdram(input addr_t a);
		return a >= SDRAM_BASE && a < SDRAM_LIMIT;
	endfunction

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			mismatch_errors++;
			$display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			mismatch_errors++;
			$display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// ar monitor samples mid-cycle so the values are those of the next edge
	always @(negedge clock) begin
		ar_hs = rst_n && arvalid && arready;
		r_hs  = rst_n && rvalid && rready;
		if (ar_hs) begin
			ar_count++;
			if (in_sdram(araddr)) begin
				line_addrs.push_back(araddr);
				if (arlen != 4'd7 || arburst != BURST_INCR || araddr[4:0] != 5'd0) begin
					protocol_errors++;
					$display("ERROR: line request at %h is not an aligned 8-beat incr burst",
						araddr);
				end
			end else begin
				check_addr("araddr", araddr, ar_pc);   // uncached pcs are asked for in order
				ar_pc = next_pc(ar_pc);
				if (arlen != 4'd0 || arburst != BURST_FIXED) begin
					protocol_errors++;
					$display("ERROR: uncached request at %h is not a single fixed beat",
						araddr);
				end
			end
		end
	end

	// output stream against the reference successor chain
	always @(negedge clock) begin
		if (rst_n) begin
			if (held_valid) begin   // stalled last edge so nothing may move
				if (!out_valid) begin
					protocol_errors++;
					$display("ERROR: out_valid dropped while out_ready was low");
				end
				check_addr("out_pc", out_pc, held_pc);
				check_word("out_inst", out_inst, held_inst);
			end
			if (out_valid && out_ready) begin
				check_addr("out_pc", out_pc, exp_pc);
				check_word("out_inst", out_inst, mem_word(exp_pc));
				if (exp_pc >= LOOP_BASE && exp_pc < LOOP_BASE + LINE_BYTES) begin
					if (loop_outs == 0)
						ar_at_loop = ar_count;   // loop line is filled by now
					loop_outs++;
				end
				exp_pc = next_pc(exp_pc);
				checked++;
			end
			held_valid = out_valid && !out_ready;
			held_pc    = out_pc;
			held_inst  = out_inst;
		end
	end

	// axi memory model and out_ready stalls driven 2 ns after the edge
	initial begin : memory_model
		int unsigned seed;
		addr_t       req_addr[$];
		logic [3:0]  req_len[$];
		logic [1:0]  req_burst[$];
		int unsigned beat_idx;
		addr_t       beat_a;
		seed = SEED;
		void'($urandom(seed));
		beat_idx = 0;
		forever begin
			@(posedge clock);
			#2;
			if (!rst_n) begin
				arready = 1'b0;
				rvalid  = 1'b0;
				rlast   = 1'b0;
			end else begin
				if (ar_hs) begin
					req_addr.push_back(araddr);
					req_len.push_back(arlen);
					req_burst.push_back(arburst);
				end
				if (r_hs) begin
					if (beat_idx == req_len[0]) begin   // burst done
						void'(req_addr.pop_front());
						void'(req_len.pop_front());
						void'(req_burst.pop_front());
						beat_idx = 0;
					end else begin
						beat_idx++;
					end
				end
				arready = ($urandom % 4) != 0;
				if (req_addr.size() != 0 && ($urandom % 3) != 0) begin
					beat_a = req_addr[0];
					if (req_burst[0] == BURST_INCR)
						beat_a = req_addr[0] + 4 * beat_idx;
					rvalid = 1'b1;
					rdata  = mem_word(beat_a);
					rlast  = (beat_idx == req_len[0]);
				end else begin
					rvalid = 1'b0;   // gap in the read data
					rlast  = 1'b0;
				end
				out_ready = ($urandom % 4) != 0;
			end
		end
	end

	initial begin : main
		int unsigned cycle;
		int unsigned idle;
		int unsigned last_checked;
		logic        timed_out;
		clock           = 1'b0;
		rst_n           = 1'b0;
		arready         = 1'b0;
		rdata           = '0;
		rresp           = 2'b00;
		rlast           = 1'b0;
		rvalid          = 1'b0;
		out_ready       = 1'b0;
		mismatch_errors = 0;
		protocol_errors = 0;
		timeout_errors  = 0;
		checked         = 0;
		loop_outs       = 0;
		ar_count        = 0;
		ar_at_loop      = 0;
		exp_pc          = RESET_PC;
		ar_pc           = RESET_PC;
		held_valid      = 1'b0;
		timed_out       = 1'b0;
		cycle           = 0;
		idle            = 0;
		last_checked    = 0;
		repeat (16) @(posedge clock);
		#2;
		rst_n = 1'b1;
		// hop chain, sdram misses, then the loop until it has run several times
		while (loop_outs < LOOP_OUTS && !timed_out) begin
			@(posedge clock);
			cycle++;
			if (checked != last_checked) begin
				idle         = 0;
				last_checked = checked;
			end else begin
				idle++;
			end
			if (idle > IDLE_LIMIT || cycle > RUN_LIMIT) begin
				timed_out = 1'b1;
				timeout_errors++;
				$display("ERROR: timed out waiting for instructions after %0d checked", checked);
			end
		end
		if (!timed_out) begin
			if (line_addrs.size() != 2) begin
				protocol_errors++;
				$display("ERROR: expected 2 line refills, saw %0d", line_addrs.size());
			end else begin
				check_addr("araddr", line_addrs[0], LINE0_BASE);
				check_addr("araddr", line_addrs[1], LOOP_BASE);
			end
			if (ar_count != ar_at_loop) begin
				protocol_errors++;
				$display("ERROR: cached loop issued %0d axi requests", ar_count - ar_at_loop);
			end
		end
		$display("errors: %0d mismatch, %0d protocol, %0d timeout; %0d instructions checked",
			mismatch_errors, protocol_errors, timeout_errors, checked);
		if (mismatch_errors + protocol_errors + timeout_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
hdl/fetch_pkg.sv
hdl/icache.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/fetch_top.sv
verification/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - hdl/fetch_pkg.sv
  - hdl/icache.sv
  - hdl/fetch_unit.sv
  - hdl/decode_stage.sv
  - hdl/fetch_top.sv
  - target: test
    files:
      - verification/fetch_tb.sv
